// ==== sim.f ====
design/ddr_test_pkg.sv
design/lane_lfsr.sv
design/pattern_generator.sv
design/address_generator.sv
design/burst_tracker.sv
design/test_sequencer.sv
design/read_checker.sv
design/ddr_test_driver.sv
tb/ddr_test_properties.sv
tb/ddr_test_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
LINTFLAGS = --lint-only --timing -Wall
TOP       = ddr_test_tb
FILELIST  = sim.f
BUILD_DIR = obj_dir
LOG       = sim.log
FAIL_MSG  = Simulation FAILED
PASS_MSG  = Simulation PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	-./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "run failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "run incomplete, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tb/ddr_test_trace.txt ====
// per test: ready stall mask, read latency in cycles,
// faulted read beat (ffffffff for none), faulted byte lane
ffffffff 00000001 ffffffff 00000000
a5a5a5a5 00000004 ffffffff 00000000
ffffffff 00000002 00000005 00000002
3c3c3c3c 00000007 000000b4 00000001
0f0f0f0f 00000003 ffffffff 00000000

// ==== tb/ddr_test_tb.sv ====
//----------------------------------------
// ddr_test_tb
// drives the traffic generator against a
// memory model, with ready stalls, read
// latency and fault injection per test
//----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module ddr_test_tb;

  localparam int burst_len      = 2;
  localparam int max_row        = 3;
  localparam int max_col        = 16;
  localparam int max_bank       = 3;
  localparam int cols_per_row   = max_col / (2 * burst_len) + 1;
  localparam int bursts         = cols_per_row * (max_row + 1) * (max_bank + 1);
  localparam int sweep_beats    = bursts * burst_len;
  localparam int timeout_cycles = 20000;
  localparam int reset_cycles   = 16;
  localparam int max_tests      = 16;

  logic        clk;
  logic        reset_n;
  logic        local_ready;
  logic        local_rdata_valid;
  logic [31:0] local_rdata;
  logic        local_write_req;
  logic        local_read_req;
  logic        local_burstbegin;
  logic [1:0]  local_bank_addr;
  logic [12:0] local_row_addr;
  logic [8:0]  local_col_addr;
  logic [1:0]  local_size;
  logic [3:0]  local_be;
  logic [31:0] local_wdata;
  logic [3:0]  pnf_per_byte;
  logic        pnf_persist;
  logic        test_complete;
  logic [7:0]  test_status;

  // four words per test
  logic [31:0] trace_words [4*max_tests];
  logic [31:0] mem [int];
  logic [31:0] rd_data_q [$];
  int          rd_time_q [$];
  logic [7:0]  lane_state [4];
  logic [31:0] stall_mask;
  logic [23:0] wr_addr;
  int cyc;
  int latency;
  int fault_beat;
  int fault_lane;
  int fault_edge;
  int wbeats;
  int rreqs;
  int rbeats;
  int test_errors;
  int errors;
  int failed_tests;
  int tests;

  ddr_test_driver #(
    .burst_len(burst_len), .max_row(max_row), .max_col(max_col), .max_bank(max_bank)
  ) dut (
    .clk(clk), .reset_n(reset_n), .local_ready(local_ready),
    .local_rdata_valid(local_rdata_valid), .local_rdata(local_rdata),
    .local_write_req(local_write_req), .local_read_req(local_read_req),
    .local_burstbegin(local_burstbegin), .local_bank_addr(local_bank_addr),
    .local_row_addr(local_row_addr), .local_col_addr(local_col_addr),
    .local_size(local_size), .local_be(local_be), .local_wdata(local_wdata),
    .pnf_per_byte(pnf_per_byte), .pnf_persist(pnf_persist),
    .test_complete(test_complete), .test_status(test_status)
  );

  always #5 clk = ~clk;

  // taps on bits 7, 5, 4 and 3 for x^8+x^6+x^5+x^4+1
  function automatic logic [7:0] lfsr_step(input logic [7:0] d);
    return {d[6:0], d[7] ^ d[5] ^ d[4] ^ d[3]};
  endfunction

  // bank/row/column of burst j within one sweep
  function automatic logic [23:0] addr_of(input int j);
    logic [1:0]  bank;
    logic [12:0] row;
    logic [8:0]  col;
    col  = 9'((j % cols_per_row) * 2 * burst_len);
    row  = 13'((j / cols_per_row) % (max_row + 1));
    bank = 2'(j / (cols_per_row * (max_row + 1)));
    return {bank, row, col};
  endfunction

  function automatic int mem_key(input logic [23:0] addr, input int beat);
    return int'({6'd0, addr, 2'(beat)});
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("mismatch %s: got %h expected %h at cycle %0d", name, got, exp, cyc);
    test_errors++;
  endtask

  // one clock of the memory model at the falling edge
  task automatic service_port();
    logic        ready_now;
    int          sweep;
    int          beat;
    int          key;
    int          i;
    logic [23:0] dut_addr;
    logic [23:0] exp_addr;
    logic [31:0] word;
    logic [31:0] exp_data;
    logic [3:0]  exp_be;
    logic [3:0]  exp_pnf;
    logic [7:0]  exp_status;
    @(negedge clk);
    cyc++;
    dut_addr = {local_bank_addr, local_row_addr, local_col_addr};

    // faulted lane shows up three falling edges after its beat
    if (fault_edge < 0 || cyc < fault_edge + 3)
    begin
      if (pnf_per_byte != 4'hf)
        report_mismatch("pnf_per_byte", 32'(pnf_per_byte), 32'hf);
    end
    else if (cyc == fault_edge + 3)
    begin
      exp_pnf = 4'hf ^ (4'd1 << fault_lane);
      if (pnf_per_byte != exp_pnf)
        report_mismatch("pnf_per_byte", 32'(pnf_per_byte), 32'(exp_pnf));
    end
    if (fault_edge >= 0 && cyc >= fault_edge + 4 && pnf_persist)
      report_mismatch("pnf_persist", 32'(pnf_persist), 32'h0);
    // nothing read back yet
    if (rbeats == 0 && pnf_persist)
      report_mismatch("pnf_persist", 32'(pnf_persist), 32'h0);

    ready_now   = stall_mask[0];
    stall_mask  = {stall_mask[30:0], stall_mask[31]};
    local_ready = ready_now;

    if (local_write_req && ready_now)
    begin
      // sweep 0 is the sequential pattern, 1 the clear, 2 the masked pattern
      sweep = wbeats / sweep_beats;
      beat  = wbeats % burst_len;
      if (local_burstbegin != (beat == 0))
        report_mismatch("local_burstbegin", 32'(local_burstbegin), 32'(beat == 0));
      exp_status = (sweep == 0) ? 8'h01 : 8'h02;
      if (test_status != exp_status)
        report_mismatch("test_status", 32'(test_status), 32'(exp_status));
      if (beat == 0)
      begin
        exp_addr = addr_of((wbeats % sweep_beats) / burst_len);
        if (dut_addr != exp_addr)
          report_mismatch("write address", 32'(dut_addr), 32'(exp_addr));
        wr_addr = dut_addr;
      end
      if (sweep == 1)
      begin
        exp_data = '0;
        exp_be   = 4'hf;
      end
      else
      begin
        exp_data = {lane_state[3], lane_state[2], lane_state[1], lane_state[0]};
        exp_be   = (sweep == 0) ? 4'hf : 4'(4'd1 << ((wbeats % sweep_beats) % 4));
        for (i = 0; i < 4; i++)
          lane_state[i] = lfsr_step(lane_state[i]);
      end
      if (local_wdata != exp_data)
        report_mismatch("local_wdata", local_wdata, exp_data);
      if (local_be != exp_be)
        report_mismatch("local_be", 32'(local_be), 32'(exp_be));
      key  = mem_key(wr_addr, beat);
      word = mem.exists(key) ? mem[key] : '0;
      for (i = 0; i < 4; i++)
        if (local_be[i])
          word[8*i +: 8] = local_wdata[8*i +: 8];
      mem[key] = word;
      wbeats++;
    end

    if (local_read_req && ready_now)
    begin
      exp_addr = addr_of(rreqs % bursts);
      if (dut_addr != exp_addr)
        report_mismatch("read address", 32'(dut_addr), 32'(exp_addr));
      if (!local_burstbegin)
        report_mismatch("local_burstbegin", 32'(local_burstbegin), 32'h1);
      exp_status = (rreqs < bursts) ? 8'h01 : 8'h02;
      if (test_status != exp_status)
        report_mismatch("test_status", 32'(test_status), 32'(exp_status));
      for (i = 0; i < burst_len; i++)
      begin
        key = mem_key(dut_addr, i);
        rd_data_q.push_back(mem.exists(key) ? mem[key] : '0);
        rd_time_q.push_back(cyc + latency);
      end
      rreqs++;
    end

    // return read beats in order once their latency has run out
    if (rd_time_q.size() > 0 && rd_time_q[0] <= cyc)
    begin
      word = rd_data_q.pop_front();
      rd_time_q.delete(0);
      if (rbeats == fault_beat)
      begin
        word[8*fault_lane +: 8] = ~word[8*fault_lane +: 8];
        fault_edge = cyc;
      end
      rbeats++;
      local_rdata_valid = 1'b1;
      local_rdata       = word;
    end
    else
    begin
      local_rdata_valid = 1'b0;
      local_rdata       = '0;
    end
  endtask

  task automatic run_test(input int idx);
    int waited;
    stall_mask  = trace_words[4*idx];
    latency     = int'(trace_words[4*idx+1]);
    fault_beat  = (trace_words[4*idx+2] == 32'hffffffff) ? -1 : int'(trace_words[4*idx+2]);
    fault_lane  = int'(trace_words[4*idx+3]);
    fault_edge  = -1;
    cyc         = 0;
    wbeats      = 0;
    rreqs       = 0;
    rbeats      = 0;
    test_errors = 0;
    waited      = 0;
    mem.delete();
    rd_data_q.delete();
    rd_time_q.delete();
    // lane seeds from the low lane up
    lane_state[0] = 8'd1;
    lane_state[1] = 8'd11;
    lane_state[2] = 8'd21;
    lane_state[3] = 8'd31;

    @(negedge clk);
    reset_n           = 1'b0;
    local_ready       = 1'b0;
    local_rdata_valid = 1'b0;
    local_rdata       = '0;
    repeat (reset_cycles) @(negedge clk);

    // outputs while reset is held
    if ({local_write_req, local_read_req, local_burstbegin} != 3'b000)
      report_mismatch("local_write_req, local_read_req, local_burstbegin",
                      32'({local_write_req, local_read_req, local_burstbegin}), 32'h0);
    if (test_status != 8'h00)
      report_mismatch("test_status", 32'(test_status), 32'h0);
    if (pnf_persist)
      report_mismatch("pnf_persist", 32'(pnf_persist), 32'h0);
    if (pnf_per_byte != 4'hf)
      report_mismatch("pnf_per_byte", 32'(pnf_per_byte), 32'hf);
    if (local_be != 4'hf)
      report_mismatch("local_be", 32'(local_be), 32'hf);
    reset_n = 1'b1;

    while (!test_complete && waited < timeout_cycles)
    begin
      service_port();
      waited++;
    end

    if (!test_complete)
    begin
      $display("test %0d: test_complete did not rise within %0d cycles", idx, timeout_cycles);
      test_errors++;
    end
    else
    begin
      if (test_status != 8'h80)
        report_mismatch("test_status", 32'(test_status), 32'h80);
      if (pnf_persist != (fault_beat < 0))
        report_mismatch("pnf_persist", 32'(pnf_persist), 32'(fault_beat < 0));
      if (int'(local_size) != burst_len)
        report_mismatch("local_size", 32'(local_size), 32'(burst_len));
      if (wbeats != 3 * sweep_beats)
        report_mismatch("write beat count", 32'(wbeats), 32'(3 * sweep_beats));
      if (rreqs != 2 * bursts)
        report_mismatch("read request count", 32'(rreqs), 32'(2 * bursts));
      if (rbeats != 2 * sweep_beats)
        report_mismatch("read beat count", 32'(rbeats), 32'(2 * sweep_beats));
      if (fault_beat >= 0 && fault_edge < 0)
      begin
        $display("test %0d: the faulted read beat was never returned", idx);
        test_errors++;
      end
    end

    $display("test %0d: mask %h latency %0d fault beat %0d lane %0d, %s, %0d errors",
             idx, trace_words[4*idx], latency, fault_beat, fault_lane,
             (test_errors == 0) ? "ok" : "failed", test_errors);
    errors += test_errors;
    if (test_errors != 0)
      failed_tests++;
  endtask

  initial
  begin
    clk               = 1'b0;
    reset_n           = 1'b0;
    local_ready       = 1'b0;
    local_rdata_valid = 1'b0;
    local_rdata       = '0;
    errors            = 0;
    failed_tests      = 0;
    tests             = 0;
    $readmemh("tb/ddr_test_trace.txt", trace_words);

    // a zero or unread stall mask ends the list
    while (tests < max_tests && !$isunknown(trace_words[4*tests])
           && trace_words[4*tests] != 32'h0)
    begin
      run_test(tests);
      tests++;
    end
    if (tests == 0)
    begin
      $display("no tests found in the trace file");
      errors++;
    end

    $display("tests run %0d, tests failed %0d, errors %0d", tests, failed_tests, errors);
    if (errors == 0)
      $display("Simulation PASSED");
    else
      $display("Simulation FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb/ddr_test_properties.sv ====
//----------------------------------------
// ddr_test_properties
// local port protocol checks, bound into
// the traffic generator top level
//----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module ddr_test_properties (
  input  logic        clk,
  input  logic        reset_n,
  input  logic        local_ready,
  input  logic        local_write_req,
  input  logic        local_read_req,
  input  logic [1:0]  local_bank_addr,
  input  logic [12:0] local_row_addr,
  input  logic [8:0]  local_col_addr,
  input  logic [31:0] local_wdata,
  input  logic [3:0]  local_be,
  input  logic [7:0]  test_status
);

  logic [23:0] addr;

  assign addr = {local_bank_addr, local_row_addr, local_col_addr};

  // a stalled write keeps address, data and enables
  assert property (@(posedge clk) disable iff (!reset_n)
    (local_write_req && !local_ready) |=>
      ($stable(addr) && $stable(local_wdata) && $stable(local_be)))
    else $error("write request changed while local_ready was low");

  // a stalled read keeps its address
  assert property (@(posedge clk) disable iff (!reset_n)
    (local_read_req && !local_ready) |=> $stable(addr))
    else $error("read address changed while local_ready was low");

  assert property (@(posedge clk) disable iff (!reset_n)
    !(local_write_req && local_read_req))
    else $error("write and read requests high together");

  assert property (@(posedge clk) disable iff (!reset_n) test_status[6:2] == 5'd0)
    else $error("test_status reserved bits not zero");

endmodule

bind ddr_test_driver ddr_test_properties u_props (
  .clk(clk), .reset_n(reset_n), .local_ready(local_ready),
  .local_write_req(local_write_req), .local_read_req(local_read_req),
  .local_bank_addr(local_bank_addr), .local_row_addr(local_row_addr),
  .local_col_addr(local_col_addr), .local_wdata(local_wdata), .local_be(local_be),
  .test_status(test_status)
);

`default_nettype wire

// ==== design/ddr_test_driver.sv ====
//--------------------------------------
// ddr_test_driver
// traffic generator and checker for the
// memory controller local port
//--------------------------------------
`timescale 1ns/1ps
`default_nettype none

module ddr_test_driver #(
  parameter int burst_len = 2,
  parameter int max_row   = 3,
  parameter int max_col   = 16,
  parameter int max_bank  = 3
) (
  input  logic                              clk,
  input  logic                              reset_n,
  input  logic                              local_ready,
  input  logic                              local_rdata_valid,
  input  logic [ddr_test_pkg::data_w-1:0]   local_rdata,
  output logic                              local_write_req,
  output logic                              local_read_req,
  output logic                              local_burstbegin,
  output logic [ddr_test_pkg::bank_w-1:0]   local_bank_addr,
  output logic [ddr_test_pkg::row_w-1:0]    local_row_addr,
  output logic [ddr_test_pkg::col_w-1:0]    local_col_addr,
  output logic [ddr_test_pkg::size_w-1:0]   local_size,
  output logic [ddr_test_pkg::lanes-1:0]    local_be,
  output logic [ddr_test_pkg::data_w-1:0]   local_wdata,
  output logic [ddr_test_pkg::lanes-1:0]    pnf_per_byte,
  output logic                              pnf_persist,
  output logic                              test_complete,
  output logic [7:0]                        test_status
);

  logic                            last_addr;
  logic                            burst_done;
  logic                            reads_idle;
  logic                            addr_restart;
  logic                            pattern_reload;
  logic                            pattern_capture;
  logic                            zero_data;
  logic                            seq_mode;
  logic                            dm_mode;
  logic                            write_beat;
  logic                            addr_step;
  logic                            lane_advance;
  logic                            be_rotate;
  logic [ddr_test_pkg::data_w-1:0] expected;

  // ---------------------------------------
  // beat and step qualifiers
  // ---------------------------------------
  assign write_beat   = local_write_req & local_ready;
  assign addr_step    = ((local_write_req & local_burstbegin) | local_read_req) & local_ready;
  assign lane_advance = write_beat | local_rdata_valid;
  assign be_rotate    = lane_advance & dm_mode;

  assign local_size  = burst_len[ddr_test_pkg::size_w-1:0];
  assign test_status = {test_complete, 5'b00000, dm_mode, seq_mode};

  test_sequencer #(.burst_len(burst_len)) u_seq (
    .clk(clk), .reset_n(reset_n), .local_ready(local_ready), .last_addr(last_addr),
    .burst_done(burst_done), .reads_idle(reads_idle), .write_req(local_write_req),
    .read_req(local_read_req), .burst_start(local_burstbegin), .addr_restart(addr_restart),
    .pattern_reload(pattern_reload), .pattern_capture(pattern_capture),
    .zero_data(zero_data), .seq_mode(seq_mode), .dm_mode(dm_mode),
    .test_complete(test_complete)
  );

  burst_tracker #(.burst_len(burst_len)) u_track (
    .clk(clk), .reset_n(reset_n), .write_req(local_write_req), .read_req(local_read_req),
    .local_ready(local_ready), .local_rdata_valid(local_rdata_valid),
    .burst_done(burst_done), .reads_idle(reads_idle)
  );

  address_generator #(
    .burst_len(burst_len), .max_row(max_row), .max_col(max_col), .max_bank(max_bank)
  ) u_addr (
    .clk(clk), .reset_n(reset_n), .restart(addr_restart), .step(addr_step),
    .bank_addr(local_bank_addr), .row_addr(local_row_addr), .col_addr(local_col_addr),
    .last_addr(last_addr)
  );

  pattern_generator u_pat (
    .clk(clk), .reset_n(reset_n), .advance(lane_advance), .capture(pattern_capture),
    .reload(pattern_reload), .zero_data(zero_data), .dm_mode(dm_mode),
    .rotate_be(be_rotate), .wdata(local_wdata), .expected(expected), .be(local_be)
  );

  read_checker u_chk (
    .clk(clk), .reset_n(reset_n), .rdata_valid(local_rdata_valid), .rdata(local_rdata),
    .expected(expected), .be(local_be), .pnf_per_byte(pnf_per_byte),
    .pnf_persist(pnf_persist)
  );

endmodule

`default_nettype wire

// ==== design/read_checker.sv ====
//--------------------------------------
// read_checker
// per-lane compare of read data, sticky
// pass-not-fail over the whole run
//--------------------------------------
`timescale 1ns/1ps
`default_nettype none

module read_checker (
  input  logic                            clk,
  input  logic                            reset_n,
  input  logic                            rdata_valid,
  input  logic [ddr_test_pkg::data_w-1:0] rdata,
  input  logic [ddr_test_pkg::data_w-1:0] expected,
  input  logic [ddr_test_pkg::lanes-1:0]  be,
  output logic [ddr_test_pkg::lanes-1:0]  pnf_per_byte,
  output logic                            pnf_persist
);

  logic [ddr_test_pkg::lanes-1:0] lane_ok;
  logic [ddr_test_pkg::lanes-1:0] cmp_q;
  logic [ddr_test_pkg::lanes-1:0] cap_q;
  logic                           valid_d1;
  logic                           valid_d2;
  logic                           seen;
  logic                           failed;

  for (genvar i = 0; i < ddr_test_pkg::lanes; i++)
  begin : g_cmp
    assign lane_ok[i] = (rdata[8*i +: 8] == (expected[8*i +: 8] & {8{be[i]}}));
  end

  // compare, capture on valid, output register
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      cmp_q        <= '1;
      cap_q        <= '1;
      pnf_per_byte <= '1;
      valid_d1     <= 1'b0;
      valid_d2     <= 1'b0;
      seen         <= 1'b0;
      failed       <= 1'b0;
      pnf_persist  <= 1'b0;
    end
    else
    begin
      cmp_q    <= lane_ok;
      valid_d1 <= rdata_valid;
      valid_d2 <= valid_d1;
      if (valid_d1)
        cap_q <= cmp_q;
      pnf_per_byte <= cap_q;
      seen         <= seen | valid_d2;
      // one bad lane and the run has failed for good
      failed       <= failed | (seen & ~&pnf_per_byte);
      pnf_persist  <= seen & ~failed & (&pnf_per_byte);
    end
  end

endmodule

`default_nettype wire

// ==== design/test_sequencer.sv ====
//--------------------------------------
// test_sequencer
// runs the sequential-address pass, then
// the data-mask pass, then parks in done
//--------------------------------------
`timescale 1ns/1ps
`default_nettype none

module test_sequencer #(
  parameter int burst_len = 2
) (
  input  logic clk,
  input  logic reset_n,
  input  logic local_ready,
  input  logic last_addr,
  input  logic burst_done,
  input  logic reads_idle,
  output logic write_req,
  output logic read_req,
  output logic burst_start,
  output logic addr_restart,
  output logic pattern_reload,
  output logic pattern_capture,
  output logic zero_data,
  output logic seq_mode,
  output logic dm_mode,
  output logic test_complete
);

  localparam bit multi_beat = (burst_len > 1);

  ddr_test_pkg::phase_t phase;
  logic                 final_q;
  logic                 final_burst;

  // the first beat sees the burst address before it steps
  assign final_burst = (phase == ddr_test_pkg::write_burst) ? last_addr : final_q;

  // strobes decoded from the phase register
  assign addr_restart    = (phase == ddr_test_pkg::select) || (phase == ddr_test_pkg::clear_write)
                           || (phase == ddr_test_pkg::write_drain);
  assign pattern_capture = (phase == ddr_test_pkg::select) || (phase == ddr_test_pkg::clear_write);
  assign pattern_reload  = (phase == ddr_test_pkg::write_drain);

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      phase         <= ddr_test_pkg::idle;
      write_req     <= 1'b0;
      read_req      <= 1'b0;
      burst_start   <= 1'b0;
      final_q       <= 1'b0;
      zero_data     <= 1'b0;
      seq_mode      <= 1'b0;
      dm_mode       <= 1'b0;
      test_complete <= 1'b0;
    end
    else
    begin
      case (phase)
        ddr_test_pkg::idle:
        begin
          seq_mode <= 1'b1;
          phase    <= ddr_test_pkg::select;
        end
        ddr_test_pkg::select, ddr_test_pkg::clear_write:
        begin
          // clear_write ends the zero-data sweep and starts the patterned one
          if (phase == ddr_test_pkg::clear_write)
            zero_data <= 1'b0;
          write_req   <= 1'b1;
          burst_start <= 1'b1;
          phase       <= ddr_test_pkg::write_burst;
        end
        ddr_test_pkg::write_burst, ddr_test_pkg::write_beats:
        begin
          if (phase == ddr_test_pkg::write_burst && local_ready)
            final_q <= last_addr;
          if (burst_done)
          begin
            if (final_burst)
            begin
              write_req   <= 1'b0;
              burst_start <= 1'b0;
              phase       <= zero_data ? ddr_test_pkg::clear_write : ddr_test_pkg::write_drain;
            end
            else
            begin
              burst_start <= 1'b1;
              phase       <= ddr_test_pkg::write_burst;
            end
          end
          else if (local_ready && multi_beat)
          begin
            burst_start <= 1'b0;
            phase       <= ddr_test_pkg::write_beats;
          end
        end
        ddr_test_pkg::write_drain:
          phase <= ddr_test_pkg::read_start;
        ddr_test_pkg::read_start:
        begin
          read_req    <= 1'b1;
          burst_start <= 1'b1;
          phase       <= ddr_test_pkg::read_issue;
        end
        ddr_test_pkg::read_issue:
        begin
          if (local_ready && last_addr)
          begin
            read_req    <= 1'b0;
            burst_start <= 1'b0;
            phase       <= ddr_test_pkg::read_drain;
          end
        end
        ddr_test_pkg::read_drain:
        begin
          // all read beats back before moving on
          if (reads_idle)
          begin
            if (dm_mode)
            begin
              dm_mode       <= 1'b0;
              test_complete <= 1'b1;
              phase         <= ddr_test_pkg::done;
            end
            else
            begin
              seq_mode  <= 1'b0;
              dm_mode   <= 1'b1;
              zero_data <= 1'b1;
              phase     <= ddr_test_pkg::select;
            end
          end
        end
        ddr_test_pkg::done:
          test_complete <= 1'b1;
        default:
          phase <= ddr_test_pkg::idle;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== design/burst_tracker.sv ====
//--------------------------------------
// burst_tracker
// beat count inside a write burst and
// number of read beats still owed
//--------------------------------------
`timescale 1ns/1ps
`default_nettype none

module burst_tracker #(
  parameter int burst_len = 2
) (
  input  logic clk,
  input  logic reset_n,
  input  logic write_req,
  input  logic read_req,
  input  logic local_ready,
  input  logic local_rdata_valid,
  output logic burst_done,
  output logic reads_idle
);

  localparam int last_beat_i = burst_len - 1;
  localparam logic [ddr_test_pkg::size_w-1:0] last_beat = last_beat_i[ddr_test_pkg::size_w-1:0];
  localparam logic [7:0] read_beats = burst_len[7:0];

  logic [ddr_test_pkg::size_w-1:0] beat_cnt;
  logic [7:0]                      pending;
  logic                            write_beat;
  logic                            read_accept;

  assign write_beat  = write_req & local_ready;
  assign read_accept = read_req & local_ready;
  assign burst_done  = write_beat && (beat_cnt == last_beat);
  assign reads_idle  = (pending == 8'd0);

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
      beat_cnt <= '0;
    else if (write_beat)
      beat_cnt <= burst_done ? '0 : beat_cnt + 1'b1;
  end

  // a new request and a returned beat can land in the same cycle
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
      pending <= 8'd0;
    else
      pending <= pending + (read_accept ? read_beats : 8'd0) - {7'd0, local_rdata_valid};
  end

endmodule

`default_nettype wire

// ==== design/address_generator.sv ====
//--------------------------------------
// address_generator
// sequential bank/row/column walk over a
// bounded range with end-of-range flag
//--------------------------------------
`timescale 1ns/1ps
`default_nettype none

module address_generator #(
  parameter int burst_len = 2,
  parameter int max_row   = 3,
  parameter int max_col   = 16,
  parameter int max_bank  = 3
) (
  input  logic                              clk,
  input  logic                              reset_n,
  input  logic                              restart,
  input  logic                              step,
  output logic [ddr_test_pkg::bank_w-1:0]   bank_addr,
  output logic [ddr_test_pkg::row_w-1:0]    row_addr,
  output logic [ddr_test_pkg::col_w-1:0]    col_addr,
  output logic                              last_addr
);

  localparam int col_step_i = 2 * burst_len;
  localparam logic [ddr_test_pkg::col_w-1:0]  col_step = col_step_i[ddr_test_pkg::col_w-1:0];
  localparam logic [ddr_test_pkg::col_w-1:0]  col_max  = max_col[ddr_test_pkg::col_w-1:0];
  localparam logic [ddr_test_pkg::row_w-1:0]  row_max  = max_row[ddr_test_pkg::row_w-1:0];
  localparam logic [ddr_test_pkg::bank_w-1:0] bank_max = max_bank[ddr_test_pkg::bank_w-1:0];

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      bank_addr <= '0;
      row_addr  <= '0;
      col_addr  <= '0;
    end
    else if (restart)
    begin
      bank_addr <= '0;
      row_addr  <= '0;
      col_addr  <= '0;
    end
    else if (step)
    begin
      if (col_addr >= col_max)
      begin
        col_addr <= '0;
        // row carry, then bank carry, then full wrap
        if (row_addr == row_max)
        begin
          row_addr  <= '0;
          bank_addr <= (bank_addr == bank_max) ? '0 : bank_addr + 1'b1;
        end
        else
          row_addr <= row_addr + 1'b1;
      end
      else
        col_addr <= col_addr + col_step;
    end
  end

  assign last_addr = (col_addr == col_max) && (row_addr == row_max) && (bank_addr == bank_max);

endmodule

`default_nettype wire

// ==== design/pattern_generator.sv ====
//--------------------------------------
// pattern_generator
// four LFSR lanes for write and expected
// data, reload storage, zero forcing and
// rotating byte enable for the mask pass
//--------------------------------------
`timescale 1ns/1ps
`default_nettype none

module pattern_generator (
  input  logic                              clk,
  input  logic                              reset_n,
  input  logic                              advance,
  input  logic                              capture,
  input  logic                              reload,
  input  logic                              zero_data,
  input  logic                              dm_mode,
  input  logic                              rotate_be,
  output logic [ddr_test_pkg::data_w-1:0]   wdata,
  output logic [ddr_test_pkg::data_w-1:0]   expected,
  output logic [ddr_test_pkg::lanes-1:0]    be
);

  localparam int lanes = ddr_test_pkg::lanes;
  localparam logic [lanes-1:0] lane0_be = {{(lanes - 1){1'b0}}, 1'b1};

  logic [ddr_test_pkg::data_w-1:0] lane_data;
  logic [ddr_test_pkg::data_w-1:0] reload_data;
  logic [ddr_test_pkg::data_w-1:0] be_mask;
  logic [lanes-1:0]                be_rot;
  logic                            lane_pause;

  // clear writes leave the lanes where they are
  assign lane_pause = ~advance | zero_data;

  for (genvar i = 0; i < lanes; i++)
  begin : g_lane
    lane_lfsr #(
      .seed(ddr_test_pkg::lfsr_seeds[i])
    ) u_lfsr (
      .clk    (clk),
      .reset_n(reset_n),
      .load   (reload),
      .pause  (lane_pause),
      .ldata  (reload_data[8*i +: 8]),
      .data   (lane_data[8*i +: 8])
    );

    assign be_mask[8*i +: 8] = {8{be[i]}};
  end

  // lane state at the start of a write phase
  always_ff @(posedge clk)
  begin
    if (capture)
      reload_data <= lane_data;
  end

  // one-hot enable, steps with every patterned beat and every read beat
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
      be_rot <= lane0_be;
    else if (capture | reload)
      be_rot <= lane0_be;
    else if (rotate_be & ~zero_data)
      be_rot <= {be_rot[lanes-2:0], be_rot[lanes-1]};
  end

  assign be       = (dm_mode & ~zero_data) ? be_rot : '1;
  assign wdata    = zero_data ? '0 : lane_data;
  assign expected = lane_data & be_mask;

endmodule

`default_nettype wire

// ==== design/lane_lfsr.sv ====
//--------------------------------------
// lane_lfsr
// 8-bit Fibonacci LFSR for one byte lane,
// with parallel load and pause
//--------------------------------------
`timescale 1ns/1ps
`default_nettype none

module lane_lfsr #(
  parameter logic [7:0] seed = 8'd1
) (
  input  logic       clk,
  input  logic       reset_n,
  input  logic       load,
  input  logic       pause,
  input  logic [7:0] ldata,
  output logic [7:0] data
);

  logic feedback;

  // xor of the tapped bits shifts in at bit 0
  assign feedback = ^(data & ddr_test_pkg::lfsr_taps);

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
      data <= seed;
    else if (load)
      data <= ldata;
    else if (!pause)
      data <= {data[6:0], feedback};
  end

endmodule

`default_nettype wire

// ==== design/ddr_test_pkg.sv ====
//--------------------------------------
// ddr_test_pkg
// shared widths, sequencer phases and
// LFSR constants for the DDR traffic
// generator and checker
//--------------------------------------
`default_nettype none

package ddr_test_pkg;

  // local port widths
  localparam int data_w = 32;
  localparam int lanes  = 4;
  localparam int bank_w = 2;
  localparam int row_w  = 13;
  localparam int col_w  = 9;
  localparam int size_w = 2;

  // per-lane seeds, index 0 is the low byte lane
  localparam logic [7:0] lfsr_seeds [lanes] = '{8'd1, 8'd11, 8'd21, 8'd31};

  // x^8 + x^6 + x^5 + x^4 + 1
  localparam logic [7:0] lfsr_taps = 8'hb8;

  typedef enum logic [3:0] {
    idle,
    select,
    clear_write,
    write_burst,
    write_beats,
    write_drain,
    read_start,
    read_issue,
    read_drain,
    done
  } phase_t;

endpackage

`default_nettype wire
